// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = fpu_cluster_tb
RTL_TOP    = fpu_cluster
FILELIST   = fpu_cluster.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "\*\*\* FAILED \*\*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "\*\*\* PASSED \*\*\*" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== fpu_cluster.f ====
+incdir+logic
logic/fpu_pkg.sv
logic/fpu_op_decode.sv
logic/fpu_permute_logic.sv
logic/fpu_compare.sv
logic/fpu_result.sv
logic/fpu_cluster.sv
verification/fpu_cluster_checker.sv
verification/fpu_cluster_tb.sv

// ==== logic/fpu_cluster.sv ====
//********************************************************************
// top level of the FP dispatch cluster
// decode, two execute units and the result stage, fixed latency of
// three cycles with no back-pressure
//********************************************************************

module fpu_cluster (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  fpu_pkg::fpu_req_t    in_req,
  input  logic                 inv_trap_en,
  output logic                 res_valid,
  output fpu_pkg::fpu_data_t   res_data,
  output fpu_pkg::fpu_flags_t  res_flags,
  output logic                 ret_en,
  output fpu_pkg::fpu_exc_t    ret_code
);

  logic dec_valid;
  fpu_pkg::fpu_ctrl_t dec_ctrl;
  fpu_pkg::fpu_data_t dec_a;
  fpu_pkg::fpu_data_t dec_b;
  logic [1:0] dec_perm_mode;
  logic dec_ordered;
  fpu_pkg::fpu_exec_t exec_pl;
  fpu_pkg::fpu_exec_t exec_cmp;

  fpu_op_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_req        (in_req),
    .dec_valid     (dec_valid),
    .dec_ctrl      (dec_ctrl),
    .dec_a         (dec_a),
    .dec_b         (dec_b),
    .dec_perm_mode (dec_perm_mode),
    .dec_ordered   (dec_ordered)
  );

  fpu_permute_logic u_perm_logic (
    .clk           (clk),
    .rst           (rst),
    .dec_valid     (dec_valid),
    .dec_ctrl      (dec_ctrl),
    .dec_a         (dec_a),
    .dec_b         (dec_b),
    .dec_perm_mode (dec_perm_mode),
    .exec_pl       (exec_pl)
  );

  fpu_compare u_compare (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec_ctrl    (dec_ctrl),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_ordered (dec_ordered),
    .exec_cmp    (exec_cmp)
  );

  fpu_result u_result (
    .clk         (clk),
    .rst         (rst),
    .exec_pl     (exec_pl),
    .exec_cmp    (exec_cmp),
    .inv_trap_en (inv_trap_en),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_flags   (res_flags),
    .ret_en      (ret_en),
    .ret_code    (ret_code)
  );

endmodule

// ==== logic/fpu_compare.sv ====
//********************************************************************
// single-precision compare execute unit
// scalar compare on lane 0 gives flags and a condition bit, packed
// compare gives per-lane masks; both raise invalid on NaN operands
//********************************************************************

`include "fpu_config.svh"

module fpu_compare (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dec_valid,
  input  fpu_pkg::fpu_ctrl_t   dec_ctrl,
  input  fpu_pkg::fpu_data_t   dec_a,
  input  fpu_pkg::fpu_data_t   dec_b,
  input  logic                 dec_ordered,
  output fpu_pkg::fpu_exec_t   exec_cmp
);

  localparam int LANES = `FPU_DATA_W / `FPU_LANE_W;

  fpu_pkg::fpu_flags_t lane_f [LANES];
  logic [LANES-1:0] lane_hit;
  logic [LANES-1:0] lane_inv;
  fpu_pkg::fpu_data_t cmp_data;
  fpu_pkg::fpu_flags_t cmp_flags;
  logic cmp_inv;

  function automatic logic is_nan(input fpu_pkg::fpu_lane_t x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  // quiet bit clear
  function automatic logic is_snan(input fpu_pkg::fpu_lane_t x);
    return is_nan(x) && !x[22];
  endfunction

  function automatic fpu_pkg::fpu_flags_t lane_flags(input fpu_pkg::fpu_lane_t a,
                                                     input fpu_pkg::fpu_lane_t b);
    logic a_lt;
    fpu_pkg::fpu_flags_t f;
    // sign-magnitude order, negative magnitudes run backwards
    if (a[31] != b[31]) a_lt = a[31];
    else if (a[31]) a_lt = a[30:0] > b[30:0];
    else a_lt = a[30:0] < b[30:0];
    f = '0;
    if (is_nan(a) || is_nan(b)) f[3] = 1'b1;
    else if (a == b || (a[30:0] == '0 && b[30:0] == '0)) f[0] = 1'b1;
    else if (a_lt) f[1] = 1'b1;
    else f[2] = 1'b1;
    return f;
  endfunction

  // eq, lt, le, unordered
  function automatic logic cond_hit(input fpu_pkg::fpu_flags_t f, input logic [1:0] sel);
    case (sel)
      2'd0:    return f[0];
      2'd1:    return f[1];
      2'd2:    return f[1] | f[0];
      default: return f[3];
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_f[i] = lane_flags(dec_a[i*`FPU_LANE_W +: `FPU_LANE_W],
                             dec_b[i*`FPU_LANE_W +: `FPU_LANE_W]);
      lane_hit[i] = cond_hit(lane_f[i], dec_ctrl.sel);
      lane_inv[i] = is_snan(dec_a[i*`FPU_LANE_W +: `FPU_LANE_W])
                  | is_snan(dec_b[i*`FPU_LANE_W +: `FPU_LANE_W])
                  | (dec_ordered & lane_f[i][3]);
    end
  end

  always_comb begin
    cmp_data = '0;
    if (dec_ctrl.packed_cmp) begin
      for (int i = 0; i < LANES; i++) begin
        cmp_data[i*`FPU_LANE_W +: `FPU_LANE_W] = {`FPU_LANE_W{lane_hit[i]}};
      end
      cmp_flags = '0;
      cmp_inv = |lane_inv;
    end else begin
      cmp_data[0] = lane_hit[0];
      cmp_flags = lane_f[0];
      cmp_inv = lane_inv[0];
    end
  end

  always_ff @(posedge clk) begin
    exec_cmp.valid <= dec_valid & dec_ctrl.do_cmp;
    exec_cmp.data <= cmp_data;
    exec_cmp.flags <= cmp_flags;
    exec_cmp.invalid <= cmp_inv;
    exec_cmp.is_cmp <= dec_ctrl.do_cmp;
    if (rst) begin
      exec_cmp.valid <= 1'b0;
    end
  end

  // scalar compare leaves exactly one flag a cycle later
  a_scalar_flags: assert property (
    @(posedge clk) disable iff (rst)
    dec_valid && dec_ctrl.do_cmp && !dec_ctrl.packed_cmp
      |=> exec_cmp.valid && $onehot(exec_cmp.flags)
  ) else $error("scalar compare flags %h not one-hot", exec_cmp.flags);

endmodule

// ==== logic/fpu_config.svh ====
//********************************************************************
// widths and op codes shared by the FP dispatch cluster
// include wherever a width, op code or exception code is needed
//********************************************************************

`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// operand and lane widths, two single-precision lanes per operand
`define FPU_DATA_W 64
`define FPU_LANE_W 32

// compare flags and retire exception code
`define FPU_FLAG_W 4
`define FPU_EXC_W 4
`define FPU_EXC_INVALID 4'h1

// op class encoding
`define FPU_OP_W 3
`define FPU_OP_LOGIC 3'd0
`define FPU_OP_PERM 3'd1
`define FPU_OP_CMP_S 3'd2
`define FPU_OP_PCMP_S 3'd3

// cycles from an accepted request to res_valid
`define FPU_LATENCY 3

`endif

// ==== logic/fpu_op_decode.sv ====
//********************************************************************
// decode stage of the FP dispatch cluster
// samples one request per cycle and turns the op class into unit
// enables for the execute stage
//********************************************************************

module fpu_op_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  fpu_pkg::fpu_req_t    in_req,
  output logic                 dec_valid,
  output fpu_pkg::fpu_ctrl_t   dec_ctrl,
  output fpu_pkg::fpu_data_t   dec_a,
  output fpu_pkg::fpu_data_t   dec_b,
  output logic [1:0]           dec_perm_mode,
  output logic                 dec_ordered
);

  fpu_pkg::fpu_ctrl_t ctrl_d;

  // op class to one-hot enables
  always_comb begin
    ctrl_d = '0;
    ctrl_d.sel = in_req.sel;
    case (in_req.op)
      fpu_pkg::op_logic: begin
        ctrl_d.do_logic = 1'b1;
      end
      fpu_pkg::op_perm: begin
        ctrl_d.do_perm = 1'b1;
      end
      fpu_pkg::op_cmp_s: begin
        ctrl_d.do_cmp = 1'b1;
      end
      fpu_pkg::op_pcmp_s: begin
        ctrl_d.do_cmp = 1'b1;
        ctrl_d.packed_cmp = 1'b1;
      end
      default: begin
        // unknown class leaves every unit idle
        ctrl_d.do_logic = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    dec_valid <= in_valid;
    dec_ctrl <= ctrl_d;
    dec_a <= in_req.a;
    dec_b <= in_req.b;
    dec_perm_mode <= in_req.perm_mode;
    dec_ordered <= in_req.ordered;
    if (rst) begin
      dec_valid <= 1'b0;
      dec_ctrl <= '0;
    end
  end

  // a request with a valid op class reaches exactly one unit
  a_one_unit: assert property (
    @(posedge clk) disable iff (rst)
    dec_valid |-> $onehot({dec_ctrl.do_logic, dec_ctrl.do_perm, dec_ctrl.do_cmp})
  ) else $error("decoded request enables %0d units",
                $countones({dec_ctrl.do_logic, dec_ctrl.do_perm, dec_ctrl.do_cmp}));

endmodule

// ==== logic/fpu_permute_logic.sv ====
//********************************************************************
// bitwise logic and lane permute execute unit
// one registered result per cycle for logic and perm ops
//********************************************************************

`include "fpu_config.svh"

module fpu_permute_logic (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dec_valid,
  input  fpu_pkg::fpu_ctrl_t   dec_ctrl,
  input  fpu_pkg::fpu_data_t   dec_a,
  input  fpu_pkg::fpu_data_t   dec_b,
  input  logic [1:0]           dec_perm_mode,
  output fpu_pkg::fpu_exec_t   exec_pl
);

  fpu_pkg::fpu_lane_t a_lo, a_hi, b_lo, b_hi;
  fpu_pkg::fpu_data_t logic_res;
  fpu_pkg::fpu_data_t perm_res;

  assign a_lo = dec_a[`FPU_LANE_W-1:0];
  assign a_hi = dec_a[`FPU_DATA_W-1:`FPU_LANE_W];
  assign b_lo = dec_b[`FPU_LANE_W-1:0];
  assign b_hi = dec_b[`FPU_DATA_W-1:`FPU_LANE_W];

  always_comb begin
    case (dec_ctrl.sel)
      2'd0:    logic_res = dec_a & dec_b;
      2'd1:    logic_res = dec_a | dec_b;
      2'd2:    logic_res = dec_a ^ dec_b;
      default: logic_res = dec_a & ~dec_b;
    endcase
  end

  // lane shuffle, high lane written first
  always_comb begin
    case (dec_perm_mode)
      2'd0:    perm_res = dec_a;
      2'd1:    perm_res = {a_lo, b_hi};
      2'd2:    perm_res = {a_lo, a_lo};
      default: perm_res = {b_lo, a_hi};
    endcase
  end

  always_ff @(posedge clk) begin
    exec_pl.valid <= dec_valid & (dec_ctrl.do_logic | dec_ctrl.do_perm);
    exec_pl.data <= dec_ctrl.do_perm ? perm_res : logic_res;
    exec_pl.flags <= '0;
    exec_pl.invalid <= 1'b0;
    exec_pl.is_cmp <= 1'b0;
    if (rst) begin
      exec_pl.valid <= 1'b0;
    end
  end

endmodule

// ==== logic/fpu_pkg.sv ====
//********************************************************************
// types shared by the FP dispatch cluster stages
// referenced by scoped name from each stage and the top level
//********************************************************************

`include "fpu_config.svh"

package fpu_pkg;

  typedef logic [`FPU_DATA_W-1:0] fpu_data_t;
  typedef logic [`FPU_LANE_W-1:0] fpu_lane_t;

  // {unordered, greater, less, equal}
  typedef logic [`FPU_FLAG_W-1:0] fpu_flags_t;
  typedef logic [`FPU_EXC_W-1:0] fpu_exc_t;

  typedef enum logic [`FPU_OP_W-1:0] {
    op_logic  = `FPU_OP_LOGIC,
    op_perm   = `FPU_OP_PERM,
    op_cmp_s  = `FPU_OP_CMP_S,
    op_pcmp_s = `FPU_OP_PCMP_S
  } fpu_op_e;

  // incoming request, sel is the logic function or the compare condition
  typedef struct packed {
    fpu_op_e op;
    logic [1:0] sel;
    logic [1:0] perm_mode;
    logic ordered;
    fpu_data_t a;
    fpu_data_t b;
  } fpu_req_t;

  // decoded control, unit enables are one-hot
  typedef struct packed {
    logic do_logic;
    logic do_perm;
    logic do_cmp;
    logic packed_cmp;
    logic [1:0] sel;
  } fpu_ctrl_t;

  // registered output of one execute unit
  typedef struct packed {
    logic valid;
    fpu_data_t data;
    fpu_flags_t flags;
    logic invalid;
    logic is_cmp;
  } fpu_exec_t;

endpackage

// ==== logic/fpu_result.sv ====
//********************************************************************
// result stage of the FP dispatch cluster
// merges the execute units and raises the invalid retire code when
// the trap is enabled
//********************************************************************

`include "fpu_config.svh"

module fpu_result (
  input  logic                 clk,
  input  logic                 rst,
  input  fpu_pkg::fpu_exec_t   exec_pl,
  input  fpu_pkg::fpu_exec_t   exec_cmp,
  input  logic                 inv_trap_en,
  output logic                 res_valid,
  output fpu_pkg::fpu_data_t   res_data,
  output fpu_pkg::fpu_flags_t  res_flags,
  output logic                 ret_en,
  output fpu_pkg::fpu_exc_t    ret_code
);

  fpu_pkg::fpu_exec_t pick;
  logic raise_inv;

  // at most one unit holds a valid result
  assign pick = exec_cmp.valid ? exec_cmp : exec_pl;

  // trap only on a compare that saw an invalid NaN
  assign raise_inv = pick.valid & pick.is_cmp & pick.invalid & inv_trap_en;

  always_ff @(posedge clk) begin
    res_valid <= pick.valid;
    res_data <= pick.data;
    res_flags <= pick.flags;
    ret_en <= raise_inv;
    ret_code <= raise_inv ? `FPU_EXC_INVALID : '0;
    if (rst) begin
      res_valid <= 1'b0;
      ret_en <= 1'b0;
      ret_code <= '0;
    end
  end

  // decode steers each request to a single unit
  a_single_exec: assert property (
    @(posedge clk) disable iff (rst)
    !(exec_pl.valid && exec_cmp.valid)
  ) else $error("both execute units valid in one cycle");

endmodule

// ==== verification/fpu_cluster_checker.sv ====
//********************************************************************
// scoreboard for the FP dispatch cluster testbench
// predicts every accepted request and compares the result three
// cycles later, one FAILED line per wrong field
//********************************************************************

`include "fpu_config.svh"

module fpu_cluster_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  fpu_pkg::fpu_req_t    in_req,
  input  logic                 inv_trap_en,
  input  logic                 res_valid,
  input  fpu_pkg::fpu_data_t   res_data,
  input  fpu_pkg::fpu_flags_t  res_flags,
  input  logic                 ret_en,
  input  fpu_pkg::fpu_exc_t    ret_code,
  output int                   errors,
  output int                   checked,
  output int                   pending
);

  typedef struct packed {
    fpu_pkg::fpu_data_t data;
    fpu_pkg::fpu_flags_t flags;
    logic invalid;
  } expect_t;

  expect_t expq [$];
  expect_t exp_r;
  logic [`FPU_LATENCY-1:0] req_hist;
  logic trap_q;
  logic want_ret;

  function automatic logic nan_of(input fpu_pkg::fpu_lane_t x);
    return x[30:23] == 8'hff && x[22:0] != 23'd0;
  endfunction

  function automatic logic snan_of(input fpu_pkg::fpu_lane_t x);
    return nan_of(x) && x[22] == 1'b0;
  endfunction

  function automatic logic lane_invalid(input fpu_pkg::fpu_lane_t a,
                                        input fpu_pkg::fpu_lane_t b, input logic ordered);
    return snan_of(a) || snan_of(b) || (ordered && (nan_of(a) || nan_of(b)));
  endfunction

  // {unordered, greater, less, equal}
  function automatic fpu_pkg::fpu_flags_t order_flags(input fpu_pkg::fpu_lane_t a,
                                                      input fpu_pkg::fpu_lane_t b);
    fpu_pkg::fpu_lane_t ka;
    fpu_pkg::fpu_lane_t kb;
    // map to unsigned keys that sort like the real values
    ka = a[31] ? ~a : {1'b1, a[30:0]};
    kb = b[31] ? ~b : {1'b1, b[30:0]};
    if (nan_of(a) || nan_of(b)) return 4'b1000;
    if (a[30:0] == 31'd0 && b[30:0] == 31'd0) return 4'b0001;
    if (ka == kb) return 4'b0001;
    if (ka < kb) return 4'b0010;
    return 4'b0100;
  endfunction

  // eq, lt, le, unordered
  function automatic logic cond_met(input fpu_pkg::fpu_flags_t f, input logic [1:0] sel);
    case (sel)
      2'd0:    return f[0];
      2'd1:    return f[1];
      2'd2:    return f[1] || f[0];
      default: return f[3];
    endcase
  endfunction

  function automatic expect_t ref_result(input fpu_pkg::fpu_req_t r);
    expect_t e;
    fpu_pkg::fpu_lane_t a0;
    fpu_pkg::fpu_lane_t a1;
    fpu_pkg::fpu_lane_t b0;
    fpu_pkg::fpu_lane_t b1;
    a0 = r.a[31:0];
    a1 = r.a[63:32];
    b0 = r.b[31:0];
    b1 = r.b[63:32];
    e = '0;
    case (r.op)
      fpu_pkg::op_logic: begin
        case (r.sel)
          2'd0:    e.data = r.a & r.b;
          2'd1:    e.data = r.a | r.b;
          2'd2:    e.data = r.a ^ r.b;
          default: e.data = r.a & ~r.b;
        endcase
      end
      fpu_pkg::op_perm: begin
        case (r.perm_mode)
          2'd0:    e.data = r.a;
          2'd1:    e.data = {a0, b1};
          2'd2:    e.data = {a0, a0};
          default: e.data = {b0, a1};
        endcase
      end
      fpu_pkg::op_cmp_s: begin
        e.flags = order_flags(a0, b0);
        e.data[0] = cond_met(e.flags, r.sel);
        e.invalid = lane_invalid(a0, b0, r.ordered);
      end
      default: begin
        e.data = {{32{cond_met(order_flags(a1, b1), r.sel)}},
                  {32{cond_met(order_flags(a0, b0), r.sel)}}};
        e.invalid = lane_invalid(a0, b0, r.ordered) || lane_invalid(a1, b1, r.ordered);
      end
    endcase
    return e;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, want);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      expq.delete();
      req_hist <= '0;
      trap_q <= 1'b0;
      errors = 0;
      checked = 0;
    end else begin
      // trap level the result stage saw at the same edge
      trap_q <= inv_trap_en;
      req_hist <= {req_hist[`FPU_LATENCY-2:0], in_valid};
      if (in_valid) expq.push_back(ref_result(in_req));
      if (res_valid && !req_hist[`FPU_LATENCY-1]) begin
        errors++;
        $display("res_valid high with no request three cycles earlier");
      end else if (!res_valid && req_hist[`FPU_LATENCY-1]) begin
        errors++;
        $display("no result three cycles after a request");
      end
      if (res_valid && expq.size() > 0) begin
        exp_r = expq.pop_front();
        want_ret = exp_r.invalid & trap_q;
        checked++;
        check_field("res_data", res_data, exp_r.data);
        check_field("res_flags", 64'(res_flags), 64'(exp_r.flags));
        check_field("ret_en", 64'(ret_en), 64'(want_ret));
        check_field("ret_code", 64'(ret_code), 64'(want_ret ? `FPU_EXC_INVALID : 4'h0));
      end else if (!res_valid && ret_en) begin
        errors++;
        $display("ret_en high while no result is valid");
      end
    end
    pending = expq.size();
  end

endmodule

// ==== verification/fpu_cluster_tb.sv ====
//********************************************************************
// testbench for the FP dispatch cluster
// drives logic, permute, compare and invalid cases, then sparse
// random requests; the checker module does all comparing
//********************************************************************

`include "fpu_config.svh"

module fpu_cluster_tb;

  localparam int RST_CYCLES = 8;
  localparam int IDLE_AFTER_RST = 4;
  localparam int N_SPARSE = 12;
  localparam int MAX_GAP = 6;
  localparam int N_TESTS = 6;
  localparam int N_REQ = 16 + 8 + 32 + 8 + 5 + N_SPARSE;
  // each test ends with a drain
  // trap changes and the wait before dropping the trap add idle cycles
  localparam int MAX_CYCLES = RST_CYCLES + IDLE_AFTER_RST + N_REQ + N_SPARSE * MAX_GAP
                            + 3 + `FPU_LATENCY + N_TESTS * (`FPU_LATENCY + 3) + 20;

  localparam fpu_pkg::fpu_lane_t ONE = 32'h3f80_0000;
  localparam fpu_pkg::fpu_lane_t TWO = 32'h4000_0000;
  localparam fpu_pkg::fpu_lane_t THREE = 32'h4040_0000;
  localparam fpu_pkg::fpu_lane_t NEG_ONE = 32'hbf80_0000;
  localparam fpu_pkg::fpu_lane_t QNAN = 32'h7fc0_0000;
  localparam fpu_pkg::fpu_lane_t SNAN = 32'h7f80_0001;

  // 1<2, 2>1, -1>-2, +0=-0, +inf>1, -inf<+inf, qnan vs 1, -2=-2
  localparam fpu_pkg::fpu_lane_t SC_A [8] = '{32'h3f80_0000, 32'h4000_0000,
    32'hbf80_0000, 32'h0000_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'hc000_0000};
  localparam fpu_pkg::fpu_lane_t SC_B [8] = '{32'h4000_0000, 32'h3f80_0000,
    32'hc000_0000, 32'h8000_0000, 32'h3f80_0000, 32'h7f80_0000, 32'h3f80_0000, 32'hc000_0000};

  logic clk = 1'b0;
  logic rst;
  logic in_valid;
  fpu_pkg::fpu_req_t in_req;
  logic inv_trap_en;
  logic res_valid;
  fpu_pkg::fpu_data_t res_data;
  fpu_pkg::fpu_flags_t res_flags;
  logic ret_en;
  fpu_pkg::fpu_exc_t ret_code;
  int errors;
  int checked;
  int pending;
  int cycles = 0;
  int issued;
  int prev_err;
  int prev_chk;

  always #5 clk = ~clk;

  fpu_cluster u_dut (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_req(in_req), .inv_trap_en(inv_trap_en),
    .res_valid(res_valid), .res_data(res_data), .res_flags(res_flags),
    .ret_en(ret_en), .ret_code(ret_code)
  );

  fpu_cluster_checker u_checker (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_req(in_req), .inv_trap_en(inv_trap_en),
    .res_valid(res_valid), .res_data(res_data), .res_flags(res_flags),
    .ret_en(ret_en), .ret_code(ret_code),
    .errors(errors), .checked(checked), .pending(pending)
  );

  function automatic fpu_pkg::fpu_req_t make_req(input fpu_pkg::fpu_op_e op,
      input logic [1:0] sel, input logic [1:0] mode, input logic ordered,
      input fpu_pkg::fpu_data_t a, input fpu_pkg::fpu_data_t b);
    fpu_pkg::fpu_req_t r;
    r.op = op;
    r.sel = sel;
    r.perm_mode = mode;
    r.ordered = ordered;
    r.a = a;
    r.b = b;
    return r;
  endfunction

  function automatic fpu_pkg::fpu_data_t rand_data();
    return {$urandom(), $urandom()};
  endfunction

  task automatic issue(input fpu_pkg::fpu_req_t r);
    @(posedge clk);
    in_valid <= 1'b1;
    in_req <= r;
    issued++;
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic set_trap(input logic en);
    @(posedge clk);
    in_valid <= 1'b0;
    inv_trap_en <= en;
  endtask

  // wait until every queued result came back
  task automatic finish_test(input string name);
    idle();
    do @(negedge clk); while (pending != 0);
    $display("%-10s %0d results, %0d errors", name, checked - prev_chk, errors - prev_err);
    prev_chk = checked;
    prev_err = errors;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [31:0] rnd;
    void'($urandom(32'h496c));
    rst = 1'b1;
    in_valid = 1'b0;
    in_req = '0;
    inv_trap_en = 1'b0;
    issued = 0;
    prev_err = 0;
    prev_chk = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (IDLE_AFTER_RST) idle();

    for (int i = 0; i < 16; i++) begin
      issue(make_req(fpu_pkg::op_logic, i[1:0], 2'd0, 1'b0, rand_data(), rand_data()));
    end
    finish_test("logic");

    for (int i = 0; i < 8; i++) begin
      issue(make_req(fpu_pkg::op_perm, 2'd0, i[1:0], 1'b0,
                     {32'ha1a1_0000 | i, 32'ha0a0_0000 | i},
                     {32'hb1b1_0000 | i, 32'hb0b0_0000 | i}));
    end
    finish_test("permute");

    // upper lanes are random, scalar compare ignores them
    for (int i = 0; i < 32; i++) begin
      issue(make_req(fpu_pkg::op_cmp_s, i[1:0], 2'd0, 1'b0,
                     {$urandom(), SC_A[i / 4]}, {$urandom(), SC_B[i / 4]}));
    end
    finish_test("scalar");

    for (int i = 0; i < 8; i++) begin
      issue(make_req(fpu_pkg::op_pcmp_s, i[1:0], 2'd0, 1'b0,
                     (i < 4) ? {QNAN, ONE} : {THREE, QNAN},
                     (i < 4) ? {ONE, TWO} : {THREE, NEG_ONE}));
    end
    finish_test("packed");

    set_trap(1'b1);
    issue(make_req(fpu_pkg::op_cmp_s, 2'd0, 2'd0, 1'b0, {ONE, SNAN}, {ONE, ONE}));
    issue(make_req(fpu_pkg::op_cmp_s, 2'd3, 2'd0, 1'b0, {ONE, QNAN}, {ONE, ONE}));
    issue(make_req(fpu_pkg::op_cmp_s, 2'd1, 2'd0, 1'b1, {ONE, ONE}, {ONE, QNAN}));
    issue(make_req(fpu_pkg::op_pcmp_s, 2'd0, 2'd0, 1'b0, {ONE, ONE}, {SNAN, TWO}));
    // trapped requests reach the result stage before the trap drops
    repeat (`FPU_LATENCY) idle();
    set_trap(1'b0);
    issue(make_req(fpu_pkg::op_cmp_s, 2'd2, 2'd0, 1'b1, {ONE, QNAN}, {ONE, TWO}));
    finish_test("invalid");

    rnd = $urandom();
    set_trap(rnd[0]);
    for (int i = 0; i < N_SPARSE; i++) begin
      rnd = $urandom();
      issue(make_req(fpu_pkg::fpu_op_e'({1'b0, rnd[1:0]}), rnd[3:2], rnd[5:4], rnd[6],
                     rand_data(), rand_data()));
      repeat (1 + rnd[10:8] % MAX_GAP) idle();
    end
    finish_test("sparse");

    $display("tests %0d, results %0d of %0d, errors %0d", N_TESTS, checked, issued, errors);
    if (errors == 0 && checked == issued) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
